// ==== flist.f ====
verilog/sd_dat_pkg.sv
verilog/sd_crc16.sv
verilog/dat_fifo.sv
verilog/dat_tx_phy.sv
verilog/dat_rx_phy.sv
verilog/dat_control.sv
verilog/sd_dat_top.sv
tb/sd_card_model.sv
tb/sd_dat_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the DAT path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module sd_dat_tb -f flist.f -o sd_dat_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed"
   exit $status
fi

./obj_dir/sd_dat_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit $status
fi

exit 0

// ==== tb/sd_dat_tb.sv ====
////////////////////
// Testbench for the SD DAT data path
// Writes and reads blocks through a card model and checks them
////////////////////

module sd_dat_tb;
   import sd_dat_pkg::*;

   localparam int TOTAL_BLOCKS    = 12;
   localparam int WATCHDOG_CYCLES = TOTAL_BLOCKS * 200 + 2000;

   logic         host_clk;
   logic         rst_L;
   sd_byte_t     wr_data;
   logic         wr_valid;
   logic         wr_ready;
   sd_byte_t     rd_data;
   logic         rd_valid;
   logic         rd_ready;
   logic         tx_data_init;
   logic         rx_data_init;
   blk_cnt_t     blk_count;
   xfer_status_t status;
   logic         dat_in;
   logic         dat_out;
   logic         dat_oe;
   logic         rd_arm;
   logic         corrupt;
   blk_cnt_t     rd_base;
   logic         rd_toggle;
   int           seed = 31432;
   int           done_cnt = 0;
   // Scoreboard of every byte written, and bytes popped on reads
   sd_byte_t     wr_q [$];
   sd_byte_t     got_q [$];

   sd_dat_top dut_i (
      .host_clk     (host_clk),
      .rst_L        (rst_L),
      .wr_data      (wr_data),
      .wr_valid     (wr_valid),
      .wr_ready     (wr_ready),
      .rd_data      (rd_data),
      .rd_valid     (rd_valid),
      .rd_ready     (rd_ready),
      .tx_data_init (tx_data_init),
      .rx_data_init (rx_data_init),
      .blk_count    (blk_count),
      .status       (status),
      .dat_in       (dat_in),
      .dat_out      (dat_out),
      .dat_oe       (dat_oe)
   );

   // Card paces reads on the controller's block start
   assign rd_arm = dut_i.dat_rd_flag;

   sd_card_model card_i (
      .host_clk (host_clk),
      .dat_out  (dat_out),
      .dat_oe   (dat_oe),
      .dat_in   (dat_in),
      .rd_arm   (rd_arm),
      .rd_start (rx_data_init),
      .rd_base  (rd_base),
      .corrupt  (corrupt)
   );

   initial begin
      host_clk = 1'b0;
      forever #5 host_clk = ~host_clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (exp == act) else begin
         $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
         fail_run("value check failed");
      end
   endtask

   ////////////////////
   // Protocol assertions
   ////////////////////
   assert property (@(posedge host_clk) disable iff (!rst_L)
                    status.done |-> (!status.busy && $past(status.busy)))
      else fail_run("done pulse not aligned with busy dropping");
   assert property (@(posedge host_clk) disable iff (!rst_L) dat_oe |-> status.busy)
      else fail_run("frame driven with no transfer running");
   assert property (@(posedge host_clk) disable iff (!rst_L) card_i.busy_low |-> !dat_oe)
      else fail_run("frame started while the card was busy");
   assert property (@(posedge host_clk) disable iff (!rst_L)
                    card_i.rd_sof |-> (dut_i.rx_level <= 5'(FIFO_DEPTH - BLOCK_BYTES)))
      else fail_run("read frame started without room for a block");
   assert property (@(posedge host_clk) disable iff (!rst_L) card_i.bad_frames == 0)
      else fail_run("card saw a bad start bit, end bit or CRC");

   // Host side monitor, popped bytes and done pulses
   always @(posedge host_clk) begin
      if (rd_valid && rd_ready)
         got_q.push_back(rd_data);
      if (status.done)
         done_cnt++;
   end

   // Random host back-pressure on the read side
   always @(negedge host_clk) begin : ready_toggle
      int r;
      if (rd_toggle) begin
         r        = $random(seed);
         rd_ready = r[0];
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge host_clk);
      fail_run("watchdog expired before the tests finished");
   end

   ////////////////////
   // Host tasks
   ////////////////////
   task automatic issue_cmd(input logic tx, input logic rx, input int n);
      @(negedge host_clk);
      tx_data_init = tx;
      rx_data_init = rx;
      blk_count    = 4'(n);
      @(negedge host_clk);
      tx_data_init = 1'b0;
      rx_data_init = 1'b0;
   endtask

   task automatic push_bytes(input int n);
      int r;
      for (int i = 0; i < n; i++) begin
         @(negedge host_clk);
         r        = $random(seed);
         wr_data  = r[7:0];
         wr_valid = 1'b1;
         wr_q.push_back(r[7:0]);
         // Held until the FIFO has room
         while (!wr_ready)
            @(negedge host_clk);
      end
      @(negedge host_clk);
      wr_valid = 1'b0;
   endtask

   // Returns on the falling edge where done is high
   task automatic wait_done();
      while (!status.done)
         @(negedge host_clk);
   endtask

   task automatic compare_card(input int first, input int n);
      for (int i = 0; i < n; i++)
         check_val("card_i.mem", wr_q[first + i], card_i.mem[8'(first + i)]);
   endtask

   task automatic write_blocks(input int n);
      int frames0;
      int dn0;
      frames0 = card_i.wr_frames;
      dn0     = done_cnt;
      issue_cmd(1'b1, 1'b0, n);
      check_val("status.busy", 1, status.busy);
      push_bytes(n * BLOCK_BYTES);
      wait_done();
      @(negedge host_clk);
      check_val("card_i.wr_frames", frames0 + n, card_i.wr_frames);
      check_val("done_cnt", dn0 + 1, done_cnt);
      compare_card(frames0 * BLOCK_BYTES, n * BLOCK_BYTES);
   endtask

   task automatic read_blocks(input int n, input int base, input logic exp_err);
      int frames0;
      int dn0;
      frames0 = card_i.rd_frames;
      dn0     = done_cnt;
      got_q.delete();
      rd_base = 4'(base);
      issue_cmd(1'b0, 1'b1, n);
      check_val("status.busy", 1, status.busy);
      wait_done();
      check_val("status.crc_err", exp_err, status.crc_err);
      @(negedge host_clk);
      check_val("card_i.rd_frames", frames0 + n, card_i.rd_frames);
      check_val("done_cnt", dn0 + 1, done_cnt);
      // Drain whatever the host has not popped yet
      while (got_q.size() < n * BLOCK_BYTES)
         @(negedge host_clk);
      check_val("rd_valid", 0, rd_valid);
      check_val("got_q.size", n * BLOCK_BYTES, got_q.size());
      for (int i = 0; i < n * BLOCK_BYTES; i++)
         check_val("rd_data", wr_q[base * BLOCK_BYTES + i], got_q[i]);
   endtask

   ////////////////////
   // Test sequence
   ////////////////////
   initial begin : main
      int wr0;
      int rd0;
      rst_L        = 1'b0;
      wr_data      = '0;
      wr_valid     = 1'b0;
      rd_ready     = 1'b1;
      tx_data_init = 1'b0;
      rx_data_init = 1'b0;
      blk_count    = '0;
      corrupt      = 1'b0;
      rd_base      = '0;
      rd_toggle    = 1'b0;
      repeat (4) @(negedge host_clk);
      rst_L = 1'b1;

      // Idle values out of reset
      check_val("dat_oe", 0, dat_oe);
      check_val("status.busy", 0, status.busy);
      check_val("status.done", 0, status.done);
      check_val("status.crc_err", 0, status.crc_err);
      check_val("rd_valid", 0, rd_valid);
      check_val("wr_ready", 1, wr_ready);

      // Single block, then frame fields of that block
      write_blocks(1);
      check_val("start bit", 0, card_i.last_start);
      check_val("end bit", 1, card_i.last_end);
      check_val("crc16", card_i.last_calc, card_i.last_got);

      // Three blocks out and back
      write_blocks(3);
      read_blocks(3, 1, 1'b0);

      // Same blocks under host back-pressure
      rd_toggle = 1'b1;
      read_blocks(3, 1, 1'b0);
      @(negedge host_clk);
      rd_toggle = 1'b0;
      rd_ready  = 1'b1;

      // Bad CRC from the card
      corrupt = 1'b1;
      read_blocks(1, 0, 1'b1);
      corrupt = 1'b0;

      // Both inits together are dropped, error flag untouched
      wr0 = card_i.wr_frames;
      rd0 = card_i.rd_frames;
      issue_cmd(1'b1, 1'b1, 1);
      check_val("status.busy", 0, status.busy);
      check_val("status.crc_err", 1, status.crc_err);

      // Accepted write clears the error, a read on top is dropped
      issue_cmd(1'b1, 1'b0, 1);
      check_val("status.busy", 1, status.busy);
      check_val("status.crc_err", 0, status.crc_err);
      issue_cmd(1'b0, 1'b1, 1);
      check_val("status.busy", 1, status.busy);
      push_bytes(BLOCK_BYTES);
      wait_done();
      @(negedge host_clk);
      check_val("card_i.wr_frames", wr0 + 1, card_i.wr_frames);
      check_val("card_i.rd_frames", rd0, card_i.rd_frames);
      compare_card(wr0 * BLOCK_BYTES, BLOCK_BYTES);
      repeat (20) @(negedge host_clk);
      check_val("status.busy", 0, status.busy);

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// ==== tb/sd_card_model.sv ====
////////////////////
// Behavioral SD card, DAT line only
// Stores written blocks and returns them on reads
////////////////////

module sd_card_model
   import sd_dat_pkg::*;
(
   input  logic     host_clk,
   input  logic     dat_out,
   input  logic     dat_oe,
   output logic     dat_in,
   input  logic     rd_arm,
   input  logic     rd_start,
   input  blk_cnt_t rd_base,
   input  logic     corrupt
);

   // Card storage, written blocks back to back
   sd_byte_t mem [256];
   int       wr_frames = 0;
   int       rd_frames = 0;
   int       bad_frames = 0;
   int       wr_blk = 0;
   int       rd_blk = 0;
   int       seed = 31432;
   // Fields of the last written frame
   logic     last_start;
   logic     last_end;
   crc16_t   last_got;
   crc16_t   last_calc;
   logic     busy_low = 1'b0;
   logic     rd_line = 1'b1;
   // High during the start bit of a read frame
   logic     rd_sof = 1'b0;

   // Busy wins over the read driver
   assign dat_in = rd_line & !busy_low;

   // One CRC16 step, x^16+x^12+x^5+1 as the constant 0x1021
   function automatic crc16_t crc_step(input crc16_t c, input logic b);
      crc16_t n;
      n = c << 1;
      if (c[15] ^ b)
         n = n ^ 16'h1021;
      return n;
   endfunction

   ////////////////////
   // Write capture
   ////////////////////
   initial begin : capture
      sd_byte_t b;
      forever begin
         @(posedge host_clk);
         if (dat_oe) begin
            // First driven bit is the start bit
            last_start = dat_out;
            last_calc  = '0;
            for (int i = 0; i < BLOCK_BYTES; i++) begin
               for (int k = 0; k < 8; k++) begin
                  @(posedge host_clk);
                  b         = {b[6:0], dat_out};
                  last_calc = crc_step(last_calc, dat_out);
               end
               mem[8'(wr_blk * BLOCK_BYTES + i)] = b;
            end
            for (int k = 0; k < 16; k++) begin
               @(posedge host_clk);
               last_got = {last_got[14:0], dat_out};
            end
            @(posedge host_clk);
            last_end = dat_out;
            if (last_start || !last_end || last_got != last_calc)
               bad_frames++;
            wr_frames++;
            wr_blk++;
            // Busy, line held low for 3 to 10 cycles
            @(negedge host_clk);
            busy_low = 1'b1;
            repeat (3 + {$random(seed)} % 8) @(negedge host_clk);
            busy_low = 1'b0;
         end
      end
   end

   ////////////////////
   // Read frames
   ////////////////////
   task automatic send_block();
      crc16_t   c;
      sd_byte_t b;
      int       base;
      base = rd_blk * BLOCK_BYTES;
      c    = '0;
      // Access latency 2 to 6 cycles
      repeat (2 + {$random(seed)} % 5) @(negedge host_clk);
      rd_line = 1'b0;
      rd_sof  = 1'b1;
      for (int i = 0; i < BLOCK_BYTES; i++) begin
         b = mem[8'(base + i)];
         for (int k = 0; k < 8; k++) begin
            @(negedge host_clk);
            rd_sof  = 1'b0;
            rd_line = b[7];
            c       = crc_step(c, b[7]);
            b       = b << 1;
         end
      end
      // Flip one CRC bit on request
      if (corrupt)
         c[0] = ~c[0];
      for (int k = 0; k < 16; k++) begin
         @(negedge host_clk);
         rd_line = c[15];
         c       = c << 1;
      end
      // End bit, then the line idles high
      @(negedge host_clk);
      rd_line = 1'b1;
      rd_frames++;
      rd_blk++;
   endtask

   initial begin : sender
      forever begin
         @(posedge host_clk);
         if (rd_start)
            rd_blk = int'(rd_base);
         else if (rd_arm)
            send_block();
      end
   end

endmodule

// ==== verilog/sd_dat_top.sv ====
////////////////////
// SD host DAT line data path
// Buffers, transmit and receive PHYs and the transfer controller
////////////////////

module sd_dat_top
   import sd_dat_pkg::*;
(
   input  logic         host_clk,
   input  logic         rst_L,
   input  sd_byte_t     wr_data,
   input  logic         wr_valid,
   output logic         wr_ready,
   output sd_byte_t     rd_data,
   output logic         rd_valid,
   input  logic         rd_ready,
   input  logic         tx_data_init,
   input  logic         rx_data_init,
   input  blk_cnt_t     blk_count,
   output xfer_status_t status,
   input  logic         dat_in,
   output logic         dat_out,
   output logic         dat_oe
);

   // Transmit stream, FIFO to PHY
   sd_byte_t  tx_byte;
   logic      tx_byte_valid;
   logic      tx_byte_ready;
   fifo_lvl_t tx_level;
   // Receive stream, PHY to FIFO
   sd_byte_t  rx_byte;
   logic      rx_byte_valid;
   logic      rx_byte_ready;
   fifo_lvl_t rx_level;
   // Controller handshakes
   logic      dat_wr_flag;
   logic      dat_rd_flag;
   logic      tx_blk_done;
   logic      rx_blk_done;
   logic      rx_crc_ok;

   dat_fifo tx_fifo_i (
      .host_clk  (host_clk),
      .rst_L     (rst_L),
      .in_data   (wr_data),
      .in_valid  (wr_valid),
      .in_ready  (wr_ready),
      .out_data  (tx_byte),
      .out_valid (tx_byte_valid),
      .out_ready (tx_byte_ready),
      .level     (tx_level)
   );

   dat_fifo rx_fifo_i (
      .host_clk  (host_clk),
      .rst_L     (rst_L),
      .in_data   (rx_byte),
      .in_valid  (rx_byte_valid),
      .in_ready  (rx_byte_ready),
      .out_data  (rd_data),
      .out_valid (rd_valid),
      .out_ready (rd_ready),
      .level     (rx_level)
   );

   dat_tx_phy tx_phy_i (
      .host_clk   (host_clk),
      .rst_L      (rst_L),
      .blk_start  (dat_wr_flag),
      .byte_data  (tx_byte),
      .byte_valid (tx_byte_valid),
      .byte_ready (tx_byte_ready),
      .dat_in     (dat_in),
      .dat_out    (dat_out),
      .dat_oe     (dat_oe),
      .blk_done   (tx_blk_done)
   );

   dat_rx_phy rx_phy_i (
      .host_clk   (host_clk),
      .rst_L      (rst_L),
      .blk_arm    (dat_rd_flag),
      .dat_in     (dat_in),
      .byte_data  (rx_byte),
      .byte_valid (rx_byte_valid),
      .byte_ready (rx_byte_ready),
      .blk_done   (rx_blk_done),
      .crc_ok     (rx_crc_ok)
   );

   dat_control control_i (
      .host_clk     (host_clk),
      .rst_L        (rst_L),
      .tx_data_init (tx_data_init),
      .rx_data_init (rx_data_init),
      .blk_count    (blk_count),
      .tx_level     (tx_level),
      .rx_level     (rx_level),
      .tx_blk_done  (tx_blk_done),
      .rx_blk_done  (rx_blk_done),
      .rx_crc_ok    (rx_crc_ok),
      .dat_wr_flag  (dat_wr_flag),
      .dat_rd_flag  (dat_rd_flag),
      .status       (status)
   );

endmodule

// ==== verilog/dat_control.sv ====
////////////////////
// DAT transfer controller
// Launches write and read blocks, counts them, reports status
////////////////////

module dat_control
   import sd_dat_pkg::*;
(
   input  logic         host_clk,
   input  logic         rst_L,
   input  logic         tx_data_init,
   input  logic         rx_data_init,
   input  blk_cnt_t     blk_count,
   input  fifo_lvl_t    tx_level,
   input  fifo_lvl_t    rx_level,
   input  logic         tx_blk_done,
   input  logic         rx_blk_done,
   input  logic         rx_crc_ok,
   output logic         dat_wr_flag,
   output logic         dat_rd_flag,
   output xfer_status_t status
);

   dat_state_e state;
   dat_state_e nxt_state;
   // Blocks still to finish in this transfer
   blk_cnt_t   blks_left;
   // A block has been started and its done is pending
   logic       in_flight;
   logic       done_q;
   logic       crc_err_q;
   logic       tx_buf_empty;
   logic       rx_buf_full;
   logic       cmd_ok;
   logic       blk_done;
   logic       last_blk;

   ////////////////////
   // Buffer conditions
   ////////////////////

   // Not yet a whole block to send
   assign tx_buf_empty = (tx_level < BLOCK_BYTES);
   // No room left for a whole block
   assign rx_buf_full  = ((FIFO_DEPTH - rx_level) < BLOCK_BYTES);

   // Exactly one init pulse and a legal count
   assign cmd_ok   = (tx_data_init ^ rx_data_init) && (blk_count != 0);

   // Done from the PHY that belongs to the running direction
   assign blk_done = (state == WRITE_TRANSFER && tx_blk_done) ||
                     (state == READ_TRANSFER && rx_blk_done);
   assign last_blk = blk_done && (blks_left == 1);

   ////////////////////
   // Next state and block starts
   ////////////////////
   always_comb begin
      nxt_state   = state;
      dat_wr_flag = 1'b0;
      dat_rd_flag = 1'b0;
      case (state)
         IDLE: begin
            // Commands are only taken here, so a busy one is dropped
            if (cmd_ok)
               nxt_state = tx_data_init ? WRITE_START : READ_START;
         end
         WRITE_START: begin
            if (!tx_buf_empty) begin
               dat_wr_flag = 1'b1;
               nxt_state   = WRITE_TRANSFER;
            end
         end
         WRITE_TRANSFER: begin
            // Next block once the previous one is done and data is there
            dat_wr_flag = !in_flight && !tx_buf_empty;
            if (last_blk)
               nxt_state = IDLE;
         end
         READ_START: begin
            if (!rx_buf_full) begin
               dat_rd_flag = 1'b1;
               nxt_state   = READ_TRANSFER;
            end
         end
         READ_TRANSFER: begin
            dat_rd_flag = !in_flight && !rx_buf_full;
            if (last_blk)
               nxt_state = IDLE;
         end
         default: nxt_state = IDLE;
      endcase
   end

   ////////////////////
   // Counters and flags
   ////////////////////
   always_ff @(posedge host_clk) begin
      if (!rst_L) begin
         state     <= IDLE;
         blks_left <= '0;
         in_flight <= 1'b0;
         done_q    <= 1'b0;
         crc_err_q <= 1'b0;
      end else begin
         state  <= nxt_state;
         // Done lands in the same cycle the state returns to IDLE
         done_q <= last_blk;
         if (state == IDLE && cmd_ok) begin
            blks_left <= blk_count;
            crc_err_q <= 1'b0;
         end
         if (dat_wr_flag || dat_rd_flag)
            in_flight <= 1'b1;
         else if (blk_done)
            in_flight <= 1'b0;
         if (blk_done)
            blks_left <= blks_left - 1'b1;
         // Sticky until the next accepted command
         if (state == READ_TRANSFER && rx_blk_done && !rx_crc_ok)
            crc_err_q <= 1'b1;
      end
   end

   // Host status
   always_comb begin
      status.busy    = (state != IDLE);
      status.done    = done_q;
      status.crc_err = crc_err_q;
   end

endmodule

// ==== verilog/dat_rx_phy.sv ====
////////////////////
// DAT receive PHY
// Finds the start bit, assembles bytes and checks the block CRC16
////////////////////

module dat_rx_phy
   import sd_dat_pkg::*;
(
   input  logic     host_clk,
   input  logic     rst_L,
   input  logic     blk_arm,
   input  logic     dat_in,
   output sd_byte_t byte_data,
   output logic     byte_valid,
   input  logic     byte_ready,
   output logic     blk_done,
   output logic     crc_ok
);

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_WAIT,
      RX_DATA,
      RX_CRC,
      RX_END
   } rx_state_e;

   rx_state_e                       state;
   logic [$clog2(BLOCK_BITS)-1:0]   bit_cnt;
   sd_byte_t                        shreg;
   // CRC bits as they arrive from the card
   crc16_t                          crc_rx;
   // CRC computed locally over the data bits
   crc16_t                          crc;
   logic                            crc_clear;
   logic                            crc_shift;
   logic                            byte_last_bit;

   assign byte_last_bit = (bit_cnt[2:0] == 3'd7);
   assign crc_clear     = (state == RX_WAIT);
   assign crc_shift     = (state == RX_DATA);

   sd_crc16 crc_i (
      .host_clk (host_clk),
      .rst_L    (rst_L),
      .clear    (crc_clear),
      .shift    (crc_shift),
      .bit_in   (dat_in),
      .crc      (crc)
   );

   ////////////////////
   // Frame sequencing
   ////////////////////
   always_ff @(posedge host_clk) begin
      if (!rst_L) begin
         state      <= RX_IDLE;
         bit_cnt    <= '0;
         byte_valid <= 1'b0;
         blk_done   <= 1'b0;
         crc_ok     <= 1'b0;
      end else begin
         blk_done <= 1'b0;
         // Byte stays offered until the FIFO takes it
         if (byte_ready)
            byte_valid <= 1'b0;
         case (state)
            RX_IDLE: begin
               if (blk_arm)
                  state <= RX_WAIT;
            end
            RX_WAIT: begin
               // Low level marks the start bit
               if (!dat_in) begin
                  state   <= RX_DATA;
                  bit_cnt <= '0;
               end
            end
            RX_DATA: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (byte_last_bit)
                  byte_valid <= 1'b1;
               if (bit_cnt == BLOCK_BITS - 1) begin
                  state   <= RX_CRC;
                  bit_cnt <= '0;
               end
            end
            RX_CRC: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt[3:0] == 4'd15)
                  state <= RX_END;
            end
            RX_END: begin
               // Good block needs a matching CRC and a high end bit
               blk_done <= 1'b1;
               crc_ok   <= (crc_rx == crc) && dat_in;
               state    <= RX_IDLE;
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // Payload shifters
   always_ff @(posedge host_clk) begin
      if (state == RX_DATA) begin
         shreg <= {shreg[6:0], dat_in};
         if (byte_last_bit)
            byte_data <= {shreg[6:0], dat_in};
      end
      if (state == RX_CRC)
         crc_rx <= {crc_rx[14:0], dat_in};
   end

endmodule

// ==== verilog/dat_tx_phy.sv ====
////////////////////
// DAT transmit PHY
// Sends one block frame with CRC16, then waits out card busy
////////////////////

module dat_tx_phy
   import sd_dat_pkg::*;
(
   input  logic     host_clk,
   input  logic     rst_L,
   input  logic     blk_start,
   input  sd_byte_t byte_data,
   input  logic     byte_valid,
   output logic     byte_ready,
   input  logic     dat_in,
   output logic     dat_out,
   output logic     dat_oe,
   output logic     blk_done
);

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_CRC,
      TX_END,
      TX_GAP,
      TX_BUSY
   } tx_state_e;

   tx_state_e                       state;
   // Shared counter for data bits, CRC bits and the busy gap
   logic [$clog2(BLOCK_BITS)-1:0]   bit_cnt;
   sd_byte_t                        shreg;
   crc16_t                          crc;
   logic                            crc_clear;
   logic                            crc_shift;
   logic                            byte_last_bit;

   assign byte_last_bit = (bit_cnt[2:0] == 3'd7);

   // First byte is pulled during the start bit
   // the rest on the last bit of the previous byte
   assign byte_ready = (state == TX_START) ||
                       (state == TX_DATA && byte_last_bit && bit_cnt != BLOCK_BITS - 1);

   assign crc_clear  = (state == TX_START);
   assign crc_shift  = (state == TX_DATA);

   sd_crc16 crc_i (
      .host_clk (host_clk),
      .rst_L    (rst_L),
      .clear    (crc_clear),
      .shift    (crc_shift),
      .bit_in   (shreg[7]),
      .crc      (crc)
   );

   ////////////////////
   // Line drive
   ////////////////////
   always_comb begin
      dat_oe  = 1'b0;
      dat_out = 1'b1;
      case (state)
         TX_START: begin
            dat_oe  = 1'b1;
            dat_out = 1'b0;
         end
         TX_DATA: begin
            dat_oe  = 1'b1;
            dat_out = shreg[7];
         end
         TX_CRC: begin
            // CRC is frozen here, walk it MSB first
            dat_oe  = 1'b1;
            dat_out = crc[4'd15 - bit_cnt[3:0]];
         end
         TX_END: begin
            dat_oe  = 1'b1;
         end
         default: begin
         end
      endcase
   end

   ////////////////////
   // Phase sequencing
   ////////////////////
   always_ff @(posedge host_clk) begin
      if (!rst_L) begin
         state    <= TX_IDLE;
         bit_cnt  <= '0;
         blk_done <= 1'b0;
      end else begin
         blk_done <= 1'b0;
         case (state)
            TX_IDLE: begin
               if (blk_start)
                  state <= TX_START;
            end
            TX_START: begin
               state   <= TX_DATA;
               bit_cnt <= '0;
            end
            TX_DATA: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == BLOCK_BITS - 1) begin
                  state   <= TX_CRC;
                  bit_cnt <= '0;
               end
            end
            TX_CRC: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt[3:0] == 4'd15)
                  state <= TX_END;
            end
            TX_END: begin
               state   <= TX_GAP;
               bit_cnt <= '0;
            end
            TX_GAP: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == BUSY_GAP - 1)
                  state <= TX_BUSY;
            end
            TX_BUSY: begin
               // Card releases busy by letting the line go high
               if (dat_in) begin
                  blk_done <= 1'b1;
                  state    <= TX_IDLE;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // Data shifter, reloaded at each byte boundary
   always_ff @(posedge host_clk) begin
      if (byte_ready && byte_valid)
         shreg <= byte_data;
      else if (state == TX_DATA)
         shreg <= {shreg[6:0], 1'b0};
   end

endmodule

// ==== verilog/dat_fifo.sv ====
////////////////////
// Byte FIFO
// Circular buffer with valid/ready on both sides and a fill level
////////////////////

module dat_fifo
   import sd_dat_pkg::*;
(
   input  logic      host_clk,
   input  logic      rst_L,
   input  sd_byte_t  in_data,
   input  logic      in_valid,
   output logic      in_ready,
   output sd_byte_t  out_data,
   output logic      out_valid,
   input  logic      out_ready,
   output fifo_lvl_t level
);

   sd_byte_t                        mem [FIFO_DEPTH];
   logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
   logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
   fifo_lvl_t                       count;
   logic                            push;
   logic                            pop;

   // Handshakes on each side
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   assign in_ready  = (count != FIFO_DEPTH);
   assign out_valid = (count != 0);
   // Head of the queue is always presented
   assign out_data  = mem[rd_ptr];
   assign level     = count;

   ////////////////////
   // Pointers and level
   ////////////////////
   always_ff @(posedge host_clk) begin
      if (!rst_L) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         // Push and pop together leave the level alone
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   // Storage
   always_ff @(posedge host_clk) begin
      if (push)
         mem[wr_ptr] <= in_data;
   end

endmodule

// ==== verilog/sd_crc16.sv ====
////////////////////
// SD CRC16 generator
// Bit serial, polynomial x^16+x^12+x^5+1
////////////////////

module sd_crc16
   import sd_dat_pkg::*;
(
   input  logic   host_clk,
   input  logic   rst_L,
   input  logic   clear,
   input  logic   shift,
   input  logic   bit_in,
   output crc16_t crc
);

   logic feedback;

   // MSB out xor incoming bit drives the taps
   assign feedback = crc[15] ^ bit_in;

   always_ff @(posedge host_clk) begin
      if (!rst_L) begin
         crc <= '0;
      end else if (clear) begin
         crc <= '0;
      end else if (shift) begin
         // Taps at bits 12, 5 and 0
         crc <= {crc[14:12], crc[11] ^ feedback, crc[10:5], crc[4] ^ feedback,
                 crc[3:0], feedback};
      end
   end

endmodule

// ==== verilog/sd_dat_pkg.sv ====
////////////////////
// SD DAT path shared definitions
// Block geometry, width types, controller states and host status
////////////////////

package sd_dat_pkg;

   ////////////////////
   // Block geometry
   ////////////////////

   // Bytes per block, kept small so simulation stays short
   localparam int BLOCK_BYTES = 8;
   // Data bits in one frame, sent MSB first
   localparam int BLOCK_BITS  = BLOCK_BYTES * 8;
   // Each buffer holds two full blocks
   localparam int FIFO_DEPTH  = 16;
   // Largest block count that fits blk_cnt_t
   localparam int MAX_BLOCKS  = 15;
   // Cycles after the end bit before card busy is sampled
   localparam int BUSY_GAP    = 2;

   ////////////////////
   // Width types
   ////////////////////

   // One data byte
   typedef logic [7:0]  sd_byte_t;
   // Block count of a transfer
   typedef logic [3:0]  blk_cnt_t;
   // CRC16 value
   typedef logic [15:0] crc16_t;
   // FIFO fill level, 0 up to FIFO_DEPTH
   typedef logic [4:0]  fifo_lvl_t;

   ////////////////////
   // Transfer controller states
   ////////////////////

   typedef enum logic [2:0] {
      IDLE,
      WRITE_START,
      WRITE_TRANSFER,
      READ_START,
      READ_TRANSFER
   } dat_state_e;

   // Status seen by the host
   // busy is high for the whole transfer, done pulses once at the end
   typedef struct packed {
      logic busy;
      logic done;
      logic crc_err;
   } xfer_status_t;

endpackage
